// File: hdl/pcw_pkg.sv
/*
 * PCW system glue shared definitions
 * Port map, system-control commands, page register layout and palette
 */
`default_nettype none

package pcw_pkg;

    // Bus and colour widths
    localparam int IO_ADDR_W   = 8;     // I/O port number
    localparam int CPU_ADDR_W  = 16;    // Z80 address
    localparam int PHYS_ADDR_W = 21;    // 2M byte space
    localparam int RGB_W       = 18;    // 6-6-6

    // Page register, PCW or CPC decode of the same byte
    typedef union packed {
        struct packed {
            logic       mode;           // High selects PCW paging
            logic [6:0] bank;           // 16K bank
        } pcw;
        struct packed {
            logic       mode;
            logic [2:0] rd_bank;        // Bank for reads
            logic       spare;
            logic [2:0] wr_bank;        // Bank for writes, and locked reads
        } cpc;
    } page_reg_t;

    // I/O ports
    localparam logic [7:0] PORT_PAGE0    = 8'hf0;
    localparam logic [7:0] PORT_PAGE1    = 8'hf1;
    localparam logic [7:0] PORT_PAGE2    = 8'hf2;
    localparam logic [7:0] PORT_PAGE3    = 8'hf3;
    localparam logic [7:0] PORT_LOCK     = 8'hf4;  // CPC read lock, read clears timer
    localparam logic [7:0] PORT_ROLLER   = 8'hf5;
    localparam logic [7:0] PORT_YSCROLL  = 8'hf6;
    localparam logic [7:0] PORT_INVERSE  = 8'hf7;
    localparam logic [7:0] PORT_SYSCTL   = 8'hf8;  // Command on write, status on read
    localparam logic [7:0] PORT_FAKE_END = 8'hff;  // Last fake-colour line

    // System-control commands, low nibble of F8 write
    localparam logic [3:0] CMD_DISK_NMI = 4'd2;
    localparam logic [3:0] CMD_DISK_INT = 4'd3;
    localparam logic [3:0] CMD_DISK_OFF = 4'd4;

    // Values after reset, banks 0..3 in PCW mode
    localparam logic [7:0] PAGE0_RESET = 8'h80;
    localparam logic [7:0] PAGE1_RESET = 8'h81;
    localparam logic [7:0] PAGE2_RESET = 8'h82;
    localparam logic [7:0] PAGE3_RESET = 8'h83;
    localparam logic [7:0] LOCK_RESET  = 8'hf1;

    localparam int TIMER_CLEAR_CYCLES = 32;   // F4 read to timer clear

    // Monitor colours, R G B
    localparam logic [RGB_W-1:0] RGB_BLACK = 18'b000000_000000_000000;
    localparam logic [RGB_W-1:0] RGB_WHITE = 18'b111111_111111_110111;
    localparam logic [RGB_W-1:0] RGB_GREEN = 18'b011001_111111_011001;
    localparam logic [RGB_W-1:0] RGB_AMBER = 18'b111111_101100_000000;

    // CGA tables, black / c1 / c2 / c3
    localparam logic [RGB_W-1:0] CGA0_LOW [4] = '{RGB_BLACK, 18'b000000_101011_000000,
        18'b101011_000000_000000, 18'b101011_010110_000000};
    localparam logic [RGB_W-1:0] CGA0_HIGH [4] = '{RGB_BLACK, 18'b010110_111111_010110,
        18'b111111_010110_010110, 18'b111111_111111_010110};
    localparam logic [RGB_W-1:0] CGA1_HIGH [4] = '{RGB_BLACK, 18'b010110_111111_111111,
        18'b111111_010110_111111, RGB_WHITE};

endpackage

`default_nettype wire

// File: hdl/pcw_ifs.sv
/*
 * Internal links of the system glue
 * Page map from the port file to the pager, interrupt control both ways
 */
`timescale 1ns/1ps
`default_nettype none

interface page_map_if import pcw_pkg::*; ();
    page_reg_t  page [4];   // F0..F3, one per 16K region
    logic [7:0] lock;       // F4, bits 7:4 lock CPC reads

    modport owner  (output page, lock);
    modport reader (input  page, lock);
endinterface

interface irq_ctl_if;
    logic       disk_to_nmi;        // FDC routed to NMI
    logic       disk_to_int;        // FDC routed to INT
    logic       mode_change;        // Pulse on commands 3 and 4
    logic       timer_clear_start;  // Pulse on F4 read
    logic       fdc_status;         // Back to the F8 status byte
    logic [3:0] timer_misses;

    modport ports (
        output disk_to_nmi, disk_to_int, mode_change, timer_clear_start,
        input  fdc_status, timer_misses
    );
    modport irq (
        input  disk_to_nmi, disk_to_int, mode_change, timer_clear_start,
        output fdc_status, timer_misses
    );
endinterface

`default_nettype wire

// File: hdl/pcw_io_ports.sv
/*
 * I/O port register file
 * Page and lock registers, F8 command decode, status read with one-cycle response
 */
`timescale 1ns/1ps
`default_nettype none

module pcw_io_ports import pcw_pkg::*; (
    input  logic                 clk_sys,
    input  logic                 reset,
    // I/O request
    input  logic                 io_valid,
    output logic                 io_ready,
    input  logic                 io_write,
    input  logic [IO_ADDR_W-1:0] io_addr,
    input  logic [7:0]           io_wdata,
    // Read response
    output logic                 rd_valid,
    input  logic                 rd_ready,
    output logic [7:0]           rd_data,
    // Status sources
    input  logic                 vblank,
    input  logic                 ntsc,
    output logic [7:0]           fake_end,
    page_map_if.owner            pm,
    irq_ctl_if.ports             irq
);

    logic       xfer;
    logic       wr_xfer;
    logic       rd_xfer;
    logic [7:0] status;
    logic [7:0] rd_mux;

    assign io_ready = !rd_valid;           // One read in flight at a time
    assign xfer     = io_valid && io_ready;
    assign wr_xfer  = xfer && io_write;
    assign rd_xfer  = xfer && !io_write;

    // F8 status, also returned on F4
    assign status = {1'b0, vblank, irq.fdc_status, ~ntsc, irq.timer_misses};

    always_comb begin
        case (io_addr)
            PORT_SYSCTL, PORT_LOCK: rd_mux = status;
            default:                rd_mux = 8'hff;   // Floating bus
        endcase
    end

    // Register writes and command decode
    always_ff @(posedge clk_sys) begin
        if (reset) begin
            pm.page[0]            <= PAGE0_RESET;
            pm.page[1]            <= PAGE1_RESET;
            pm.page[2]            <= PAGE2_RESET;
            pm.page[3]            <= PAGE3_RESET;
            pm.lock               <= LOCK_RESET;
            fake_end              <= 8'd0;
            irq.disk_to_nmi       <= 1'b0;
            irq.disk_to_int       <= 1'b0;
            irq.mode_change       <= 1'b0;
            irq.timer_clear_start <= 1'b0;
        end else begin
            irq.mode_change       <= 1'b0;
            irq.timer_clear_start <= rd_xfer && (io_addr == PORT_LOCK);
            if (wr_xfer) begin
                case (io_addr)
                    PORT_PAGE0:    pm.page[0] <= io_wdata;
                    PORT_PAGE1:    pm.page[1] <= io_wdata;
                    PORT_PAGE2:    pm.page[2] <= io_wdata;
                    PORT_PAGE3:    pm.page[3] <= io_wdata;
                    PORT_LOCK:     pm.lock    <= io_wdata;
                    PORT_FAKE_END: fake_end   <= io_wdata;
                    // Roller, scroll and inverse have no video block to feed
                    PORT_ROLLER, PORT_YSCROLL, PORT_INVERSE: ;
                    PORT_SYSCTL: begin
                        case (io_wdata[3:0])
                            CMD_DISK_NMI: begin
                                irq.disk_to_nmi <= 1'b1;
                                irq.disk_to_int <= 1'b0;
                            end
                            CMD_DISK_INT: begin
                                irq.disk_to_nmi <= 1'b0;
                                irq.disk_to_int <= 1'b1;
                                irq.mode_change <= 1'b1;
                            end
                            CMD_DISK_OFF: begin
                                irq.disk_to_nmi <= 1'b0;
                                irq.disk_to_int <= 1'b0;
                                irq.mode_change <= 1'b1;
                            end
                            default: ;          // Other commands belong to dropped blocks
                        endcase
                    end
                    default: ;
                endcase
            end
        end
    end

    // Read response handshake
    always_ff @(posedge clk_sys) begin
        if (reset) begin
            rd_valid <= 1'b0;
        end else if (rd_xfer) begin
            rd_valid <= 1'b1;
        end else if (rd_ready) begin
            rd_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk_sys) begin
        if (rd_xfer) rd_data <= rd_mux;     // Status sampled at the transfer edge
    end

    // Pending response holds its data until taken
    assert property (@(posedge clk_sys) disable iff (reset)
        rd_valid && !rd_ready |=> rd_valid && $stable(rd_data));

endmodule

`default_nettype wire

// File: hdl/pcw_pager.sv
/*
 * Memory paging stage
 * CPU address to physical address, PCW or CPC mode, one register stage
 */
`timescale 1ns/1ps
`default_nettype none

module pcw_pager import pcw_pkg::*; #(
    parameter int BANK_BITS = 4         // 4 for 256K up to 7 for 2M
) (
    input  logic                   clk_sys,
    input  logic                   reset,
    input  logic                   mem_valid,
    output logic                   mem_ready,
    input  logic                   mem_write,
    input  logic [CPU_ADDR_W-1:0]  mem_addr,
    output logic                   phys_valid,
    input  logic                   phys_ready,
    output logic                   phys_write,
    output logic [PHYS_ADDR_W-1:0] phys_addr,
    page_map_if.reader             pm
);

    localparam int OFS_W = CPU_ADDR_W - 2;     // 16K offset

    logic [1:0]             region;
    logic [OFS_W-1:0]       offset;
    page_reg_t              pr;
    logic [6:0]             bank_mask;
    logic                   use_wr_bank;
    logic [2:0]             cpc_bank;
    logic [PHYS_ADDR_W-1:0] next_addr;

    assign region    = mem_addr[CPU_ADDR_W-1 -: 2];
    assign offset    = mem_addr[OFS_W-1:0];
    assign pr        = pm.page[region];
    assign bank_mask = 7'((8'd1 << BANK_BITS) - 8'd1);

    // CPC reads follow the write bank when the region is locked
    assign use_wr_bank = mem_write || pm.lock[{1'b1, region}];
    assign cpc_bank    = use_wr_bank ? pr.cpc.wr_bank : pr.cpc.rd_bank;

    always_comb begin
        if (pr.pcw.mode) next_addr = {pr.pcw.bank & bank_mask, offset};
        else             next_addr = {4'b0, cpc_bank, offset};    // CPC stays in low 128K
    end

    assign mem_ready = !phys_valid || phys_ready;   // Empty or draining

    always_ff @(posedge clk_sys) begin
        if (reset)          phys_valid <= 1'b0;
        else if (mem_ready) phys_valid <= mem_valid;
    end

    always_ff @(posedge clk_sys) begin
        if (mem_ready && mem_valid) begin
            phys_addr  <= next_addr;
            phys_write <= mem_write;
        end
    end

    // Stalled output must not move
    assert property (@(posedge clk_sys) disable iff (reset)
        phys_valid && !phys_ready |=> phys_valid && $stable(phys_addr)
            && $stable(phys_write));

endmodule

`default_nettype wire

// File: hdl/pcw_irq_ctrl.sv
/*
 * Interrupt control
 * Timer miss count and delayed clear, FDC routing to NMI or INT
 */
`timescale 1ns/1ps
`default_nettype none

module pcw_irq_ctrl import pcw_pkg::*; (
    input  logic    clk_sys,
    input  logic    reset,
    input  logic    fdc_int,
    input  logic    timer_tick,     // Video 300 Hz timer level
    input  logic    iff1,           // CPU interrupt enable
    irq_ctl_if.irq  irq,
    output logic    nmi_n,
    output logic    int_n
);

    localparam int CNT_W = $clog2(TIMER_CLEAR_CYCLES);

    logic [1:0]       in_d;         // Previous fdc_int, timer_tick
    logic             fdc_rise;
    logic             fdc_fall;
    logic             tick_rise;
    logic             nmi_flag;
    logic             nmi_line;
    logic             int_line;
    logic             timer_line;
    logic             clearing;
    logic [CNT_W-1:0] clear_cnt;

    assign fdc_rise  =  fdc_int    && !in_d[1];
    assign fdc_fall  = !fdc_int    &&  in_d[1];
    assign tick_rise =  timer_tick && !in_d[0];

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            in_d             <= 2'b00;
            irq.fdc_status   <= 1'b0;
            irq.timer_misses <= 4'd0;
            nmi_flag         <= 1'b0;
            nmi_line         <= 1'b0;
            int_line         <= 1'b0;
            timer_line       <= 1'b0;
            clearing         <= 1'b0;
            clear_cnt        <= '0;
        end else begin
            in_d <= {fdc_int, timer_tick};
            // FDC status follows edges, NMI flag latches on rise
            if (fdc_rise) begin
                irq.fdc_status <= 1'b1;
                if (irq.disk_to_nmi) nmi_flag <= 1'b1;
            end else if (fdc_fall) begin
                irq.fdc_status <= 1'b0;
            end
            // Lines only update on a timer tick
            if (tick_rise) begin
                if (irq.timer_misses != 4'hf) irq.timer_misses <= irq.timer_misses + 4'd1;
                timer_line <= iff1;
                nmi_line   <= nmi_flag;
                int_line   <= irq.disk_to_int && irq.fdc_status && iff1;
            end
            // Delayed clear after F4 read
            if (irq.timer_clear_start) begin
                clearing  <= 1'b1;
                clear_cnt <= '0;
            end else if (clearing) begin
                if (clear_cnt == CNT_W'(TIMER_CLEAR_CYCLES - 1)) begin
                    clearing         <= 1'b0;
                    timer_line       <= 1'b0;
                    irq.timer_misses <= 4'd0;
                end else begin
                    clear_cnt <= clear_cnt + 1'b1;
                end
            end
            // Routing change drops the stale source
            if (irq.mode_change) begin
                if (irq.disk_to_nmi) begin
                    int_line <= 1'b0;
                end else if (irq.disk_to_int) begin
                    nmi_flag <= 1'b0;
                end else begin
                    nmi_flag <= 1'b0;
                    int_line <= 1'b0;
                end
            end
        end
    end

    assign nmi_n = ~nmi_line;
    assign int_n = nmi_line ? 1'b1 : !(int_line || timer_line);  // NMI masks INT

    // Count saturates, only a clear brings it back
    assert property (@(posedge clk_sys) disable iff (reset)
        irq.timer_misses == 4'hf && !clearing |=> irq.timer_misses == 4'hf);

endmodule

`default_nettype wire

// File: hdl/pcw_palette.sv
/*
 * Pixel palette, mono monitor or CGA fake colour above a line
 */
`timescale 1ns/1ps
`default_nettype none

module pcw_palette import pcw_pkg::*; (
    input  logic             clk_sys,
    input  logic             reset,
    input  logic [1:0]       colour,            // Pixel index
    input  logic [7:0]       ypos,
    input  logic [7:0]       fake_end,          // Fake colour above this line
    input  logic [1:0]       disp_color,        // 1 green, 2 amber, else white
    input  logic [1:0]       fake_colour_mode,  // 0 off
    output logic [RGB_W-1:0] rgb
);

    logic [RGB_W-1:0] monitor;
    logic [RGB_W-1:0] mono;
    logic [RGB_W-1:0] next_rgb;
    logic             in_fake;

    always_comb begin
        case (disp_color)
            2'd1:    monitor = RGB_GREEN;
            2'd2:    monitor = RGB_AMBER;
            default: monitor = RGB_WHITE;
        endcase
    end

    assign mono    = (colour == 2'd0) ? RGB_BLACK : monitor;
    assign in_fake = (fake_colour_mode != 2'd0) && (ypos < fake_end);

    always_comb begin
        next_rgb = mono;
        if (in_fake) begin
            case (fake_colour_mode)
                2'd1:    next_rgb = CGA0_LOW[colour];
                2'd2:    next_rgb = CGA0_HIGH[colour];
                default: next_rgb = CGA1_HIGH[colour];
            endcase
        end
    end

    always_ff @(posedge clk_sys) begin
        if (reset) rgb <= RGB_BLACK;
        else       rgb <= next_rgb;      // One cycle pixel latency
    end

endmodule

`default_nettype wire

// File: hdl/pcw_core_top.sv
/*
 * PCW system-bus glue top level
 * Port registers, pager, interrupt control and palette
 */
`timescale 1ns/1ps
`default_nettype none

module pcw_core_top import pcw_pkg::*; #(
    parameter int BANK_BITS = 4
) (
    input  logic                   clk_sys,
    input  logic                   reset,
    // I/O bus
    input  logic                   io_valid,
    output logic                   io_ready,
    input  logic                   io_write,
    input  logic [IO_ADDR_W-1:0]   io_addr,
    input  logic [7:0]             io_wdata,
    output logic                   rd_valid,
    input  logic                   rd_ready,
    output logic [7:0]             rd_data,
    // Memory bus
    input  logic                   mem_valid,
    output logic                   mem_ready,
    input  logic                   mem_write,
    input  logic [CPU_ADDR_W-1:0]  mem_addr,
    output logic                   phys_valid,
    input  logic                   phys_ready,
    output logic                   phys_write,
    output logic [PHYS_ADDR_W-1:0] phys_addr,
    // Interrupt sources and lines
    input  logic                   fdc_int,
    input  logic                   timer_tick,
    input  logic                   iff1,
    output logic                   nmi_n,
    output logic                   int_n,
    // Video
    input  logic                   vblank,
    input  logic                   ntsc,
    input  logic [1:0]             colour,
    input  logic [7:0]             ypos,
    input  logic [1:0]             disp_color,
    input  logic [1:0]             fake_colour_mode,
    output logic [RGB_W-1:0]       rgb
);

    logic [7:0] fake_end;

    page_map_if pm_if ();
    irq_ctl_if  irq_if ();

    pcw_io_ports pcw_io_ports_inst (
        .clk_sys, .reset,
        .io_valid, .io_ready, .io_write, .io_addr, .io_wdata,
        .rd_valid, .rd_ready, .rd_data,
        .vblank, .ntsc, .fake_end,
        .pm  (pm_if.owner),
        .irq (irq_if.ports)
    );

    pcw_pager #(.BANK_BITS(BANK_BITS)) pcw_pager_inst (
        .clk_sys, .reset,
        .mem_valid, .mem_ready, .mem_write, .mem_addr,
        .phys_valid, .phys_ready, .phys_write, .phys_addr,
        .pm (pm_if.reader)
    );

    pcw_irq_ctrl pcw_irq_ctrl_inst (
        .clk_sys, .reset,
        .fdc_int, .timer_tick, .iff1,
        .irq (irq_if.irq),
        .nmi_n, .int_n
    );

    pcw_palette pcw_palette_inst (
        .clk_sys, .reset,
        .colour, .ypos, .fake_end, .disp_color, .fake_colour_mode,
        .rgb
    );

endmodule

`default_nettype wire

// File: verification/pcw_tb_cases.svh
/*
 * Stimulus and expected-value table for the system glue testbench
 */
`ifndef PCW_TB_CASES_SVH
`define PCW_TB_CASES_SVH

localparam int NAME_W = 8 * 12;

// What a table row does with its fields
typedef enum logic [3:0] {
    IO_WR,      // addr port, data value
    IO_RD,      // addr port, data hold cycles, expect byte
    MEM_RD,     // addr region, data stall cycles, expect bank
    MEM_WR,
    TICKS,      // addr[0] iff1, data tick count
    FDC,        // data[0] fdc_int level
    IDLE,       // data cycles
    LINES,      // expect {nmi_n, int_n}
    PIXEL       // addr ypos, data {disp_color, mode, colour}, expect rgb
} kind_t;

typedef struct packed {
    logic [NAME_W-1:0] name;
    kind_t             kind;
    logic [15:0]       addr;
    logic [15:0]       data;
    logic [20:0]       expected;
} case_t;

localparam int NUM_CASES = 46;

localparam case_t CASES [NUM_CASES] = '{
    '{"rst_rgn0",    MEM_RD, 16'h0000, 16'd0,  21'd0},     // Reset pages 80..83
    '{"rst_rgn1",    MEM_RD, 16'h4000, 16'd0,  21'd1},
    '{"rst_rgn2",    MEM_RD, 16'h8000, 16'd0,  21'd2},
    '{"rst_rgn3",    MEM_RD, 16'hc000, 16'd0,  21'd3},
    '{"rst_status",  IO_RD,  16'h00f8, 16'd0,  21'h50},    // vblank 1, ntsc 0
    '{"pcw_page0",   IO_WR,  16'h00f0, 16'h9d, 21'd0},
    '{"pcw_mask",    MEM_RD, 16'h0000, 16'd0,  21'hd},     // Bank 1d cut to 4 bits
    '{"pcw_page1",   IO_WR,  16'h00f1, 16'h8a, 21'd0},
    '{"pcw_write",   MEM_WR, 16'h4000, 16'd0,  21'ha},
    '{"lock_none",   IO_WR,  16'h00f4, 16'h00, 21'd0},
    '{"cpc_page2",   IO_WR,  16'h00f2, 16'h52, 21'd0},     // Read bank 5, write bank 2
    '{"cpc_rd_bank", MEM_RD, 16'h8000, 16'd0,  21'd5},
    '{"cpc_wr_bank", MEM_WR, 16'h8000, 16'd0,  21'd2},
    '{"lock_rgn2",   IO_WR,  16'h00f4, 16'h40, 21'd0},
    '{"cpc_locked",  MEM_RD, 16'h8000, 16'd0,  21'd2},     // Locked read takes write bank
    '{"mem_stall",   MEM_RD, 16'h4000, 16'd6,  21'ha},
    '{"rd_hold",     IO_RD,  16'h00f8, 16'd6,  21'h50},
    '{"ticks_3",     TICKS,  16'h0001, 16'd3,  21'd0},
    '{"misses_3",    IO_RD,  16'h00f8, 16'd0,  21'h53},
    '{"int_timer",   LINES,  16'h0000, 16'd0,  21'b10},
    '{"clear_read",  IO_RD,  16'h00f4, 16'd0,  21'h53},
    '{"clear_wait",  IDLE,   16'h0000, 16'd40, 21'd0},
    '{"int_cleared", LINES,  16'h0000, 16'd0,  21'b11},
    '{"misses_0",    IO_RD,  16'h00f8, 16'd0,  21'h50},
    '{"ticks_18",    TICKS,  16'h0001, 16'd18, 21'd0},
    '{"misses_sat",  IO_RD,  16'h00f8, 16'd0,  21'h5f},    // Stuck at 15
    '{"clear_sat",   IO_RD,  16'h00f4, 16'd0,  21'h5f},
    '{"sat_wait",    IDLE,   16'h0000, 16'd40, 21'd0},
    '{"cmd_nmi",     IO_WR,  16'h00f8, 16'h02, 21'd0},
    '{"fdc_rise",    FDC,    16'h0000, 16'd1,  21'd0},
    '{"tick_nmi",    TICKS,  16'h0001, 16'd1,  21'd0},
    '{"nmi_active",  LINES,  16'h0000, 16'd0,  21'b01},    // NMI masks INT
    '{"fdc_status",  IO_RD,  16'h00f8, 16'd0,  21'h71},
    '{"cmd_int",     IO_WR,  16'h00f8, 16'h03, 21'd0},
    '{"tick_int",    TICKS,  16'h0001, 16'd1,  21'd0},
    '{"int_active",  LINES,  16'h0000, 16'd0,  21'b10},
    '{"fake_end",    IO_WR,  16'h00ff, 16'h40, 21'd0},     // Fake colour up to line 63
    '{"mono_white",  PIXEL,  16'h000a, 16'h01, 21'(RGB_WHITE)},
    '{"mono_black",  PIXEL,  16'h000a, 16'h10, 21'(RGB_BLACK)},
    '{"mono_green",  PIXEL,  16'h000a, 16'h12, 21'(RGB_GREEN)},
    '{"mono_amber",  PIXEL,  16'h000a, 16'h23, 21'(RGB_AMBER)},
    '{"cga0_low",    PIXEL,  16'h000a, 16'h05, 21'(CGA0_LOW[1])},
    '{"cga0_high",   PIXEL,  16'h003f, 16'h0a, 21'(CGA0_HIGH[2])},
    '{"cga1_white",  PIXEL,  16'h0000, 16'h0f, 21'(RGB_WHITE)},
    '{"past_end",    PIXEL,  16'h0040, 16'h2f, 21'(RGB_AMBER)},  // Line 64 back to mono
    '{"disp3_white", PIXEL,  16'h00c8, 16'h31, 21'(RGB_WHITE)}
};

`endif

// File: verification/pcw_core_tb.sv
/*
 * Testbench for the PCW system glue
 * Table-driven I/O, paging, interrupt and palette checks
 */
`timescale 1ns/1ps
`default_nettype none

module pcw_core_tb import pcw_pkg::*; ();

    localparam int RESET_CYCLES = 10;
    localparam int TIMEOUT      = 50;      // Cycles allowed for any handshake

    `include "pcw_tb_cases.svh"

    localparam int WATCHDOG_NS = NUM_CASES * 200 + RESET_CYCLES * 10;

    logic                   clk_sys;
    logic                   reset;
    logic                   io_valid, io_ready, io_write;
    logic [7:0]             io_addr, io_wdata;
    logic                   rd_valid, rd_ready;
    logic [7:0]             rd_data;
    logic                   mem_valid, mem_ready, mem_write;
    logic [15:0]            mem_addr;
    logic                   phys_valid, phys_ready, phys_write;
    logic [20:0]            phys_addr;
    logic                   fdc_int, timer_tick, iff1;
    logic                   nmi_n, int_n;
    logic                   vblank, ntsc;
    logic [1:0]             colour, disp_color, fake_colour_mode;
    logic [7:0]             ypos;
    logic [RGB_W-1:0]       rgb;

    int          errors;
    int          fails;
    int          errs_before;
    logic [31:0] seed;
    case_t       tc;

    pcw_core_top #(.BANK_BITS(4)) pcw_core_top_inst (.*);

    initial begin
        clk_sys = 1'b0;
        forever #5 clk_sys = ~clk_sys;
    end

    // Inputs change 1 ns after the edge, outputs are read there too
    task automatic step();
        @(posedge clk_sys);
        #1;
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic check(input logic [NAME_W-1:0] name, input logic [20:0] want,
                         input logic [20:0] got);
        assert (got == want) else begin
            $display("CHECK FAILED %s: expected %h, actual %h", name, want, got);
            errors++;
        end
    endtask

    task automatic io_write_port(input logic [NAME_W-1:0] name, input logic [7:0] port,
                                 input logic [7:0] data);
        int n;
        n        = 0;
        io_valid = 1'b1;
        io_write = 1'b1;
        io_addr  = port;
        io_wdata = data;
        while (!io_ready && n < TIMEOUT) begin
            step();
            n++;
        end
        if (!io_ready) begin
            $display("%s: write to port %h was never accepted", name, port);
            errors++;
        end
        step();                            // Transfer edge
        io_valid = 1'b0;
        io_write = 1'b0;
        step();                            // Command pulse reaches the interrupt block
    endtask

    task automatic io_read_port(input logic [NAME_W-1:0] name, input logic [7:0] port,
                                input int hold, input logic [7:0] want);
        int n;
        n        = 0;
        io_valid = 1'b1;
        io_write = 1'b0;
        io_addr  = port;
        while (!io_ready && n < TIMEOUT) begin
            step();
            n++;
        end
        if (!io_ready) begin
            $display("%s: read of port %h was never accepted", name, port);
            errors++;
        end
        step();
        io_valid = 1'b0;
        n = 0;
        while (!rd_valid && n < TIMEOUT) begin
            step();
            n++;
        end
        if (!rd_valid) begin
            $display("%s: read of port %h never returned data", name, port);
            errors++;
        end
        // Response waits for rd_ready, bus stays blocked
        repeat (hold) begin
            check(name, {13'd0, want}, {13'd0, rd_data});
            check(name, 21'b10, {19'd0, rd_valid, io_ready});
            step();
        end
        check(name, {13'd0, want}, {13'd0, rd_data});
        rd_ready = 1'b1;
        step();
        rd_ready = 1'b0;
    endtask

    task automatic mem_access(input logic [NAME_W-1:0] name, input logic [15:0] addr,
                              input logic wr, input int stall, input logic [6:0] bank);
        logic [13:0] ofs;
        logic [20:0] want;
        int          n;
        seed       = xorshift32(seed);
        ofs        = seed[13:0];           // Random offset inside the 16K region
        want       = {bank, ofs};
        n          = 0;
        mem_valid  = 1'b1;
        mem_write  = wr;
        mem_addr   = {addr[15:14], ofs};
        phys_ready = (stall == 0);
        while (!mem_ready && n < TIMEOUT) begin
            step();
            n++;
        end
        if (!mem_ready) begin
            $display("%s: memory request was never accepted", name);
            errors++;
        end
        step();
        mem_valid = 1'b0;
        if (!phys_valid) begin
            $display("%s: no translated address one cycle after the request", name);
            errors++;
        end
        check(name, want, phys_addr);
        check(name, {20'd0, wr}, {20'd0, phys_write});
        // Stalled stage keeps its address and blocks new requests
        repeat (stall) begin
            check(name, want, phys_addr);
            check(name, 21'b10, {19'd0, phys_valid, mem_ready});
            step();
        end
        phys_ready = 1'b1;
        step();
    endtask

    task automatic pulse_ticks(input logic irq_en, input int count);
        iff1 = irq_en;
        repeat (count) begin
            timer_tick = 1'b1;
            step();
            step();
            timer_tick = 1'b0;
            step();
            step();
        end
    endtask

    task automatic show_pixel(input logic [NAME_W-1:0] name, input logic [7:0] line,
                              input logic [5:0] sel, input logic [20:0] want);
        colour           = sel[1:0];
        fake_colour_mode = sel[3:2];
        disp_color       = sel[5:4];
        ypos             = line;
        step();                            // Registered lookup
        check(name, want, {3'd0, rgb});
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns, a test is stuck", WATCHDOG_NS);
        $display("SOME TESTS FAILED");
        $finish;
    end

    initial begin
        errors = 0;
        fails  = 0;
        seed   = 32'h29a1;
        reset  = 1'b1;
        {io_valid, io_write, io_addr, io_wdata, rd_ready} = '0;
        {mem_valid, mem_write, mem_addr} = '0;
        phys_ready = 1'b1;
        {fdc_int, timer_tick, iff1} = '0;
        vblank = 1'b1;
        ntsc   = 1'b0;
        {colour, ypos, disp_color, fake_colour_mode} = '0;
        repeat (RESET_CYCLES) @(posedge clk_sys);
        #1 reset = 1'b0;
        step();

        for (int i = 0; i < NUM_CASES; i++) begin
            tc          = CASES[i];
            errs_before = errors;
            case (tc.kind)
                IO_WR:  io_write_port(tc.name, tc.addr[7:0], tc.data[7:0]);
                IO_RD:  io_read_port(tc.name, tc.addr[7:0], int'(tc.data), tc.expected[7:0]);
                MEM_RD: mem_access(tc.name, tc.addr, 1'b0, int'(tc.data), tc.expected[6:0]);
                MEM_WR: mem_access(tc.name, tc.addr, 1'b1, int'(tc.data), tc.expected[6:0]);
                TICKS:  pulse_ticks(tc.addr[0], int'(tc.data));
                FDC: begin
                    fdc_int = tc.data[0];
                    step();
                    step();
                end
                IDLE:   repeat (tc.data) step();
                LINES:  check(tc.name, tc.expected, {19'd0, nmi_n, int_n});
                PIXEL:  show_pixel(tc.name, tc.addr[7:0], tc.data[5:0], tc.expected);
                default: begin
                    $display("%s: unknown table entry kind", tc.name);
                    errors++;
                end
            endcase
            if (errors != errs_before) fails++;
            $display("test %0d %s %s", i, tc.name, (errors == errs_before) ? "ok" : "failed");
        end

        $display("%0d tests, %0d failed, %0d check errors", NUM_CASES, fails, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+verification
hdl/pcw_pkg.sv
hdl/pcw_ifs.sv
hdl/pcw_io_ports.sv
hdl/pcw_pager.sv
hdl/pcw_irq_ctrl.sv
hdl/pcw_palette.sv
hdl/pcw_core_top.sv
verification/pcw_core_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       := pcw_core_tb
FILELIST  := verilog.f
VFLAGS    := --binary --timing --assert -j 0 --top-module $(TOP)
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(shell grep -v '^+' $(FILELIST)) verification/pcw_tb_cases.svh

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	@if grep -q "SOME TESTS FAILED" $(LOG); then exit 1; fi
	@grep -q "ALL TESTS PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
